//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/icache_addr_pkg.sv
      - design/icache_line_pkg.sv
      - design/sram_1p.sv
      - design/icache_lookup.sv
      - design/icache_compare.sv
      - design/icache_refill.sv
      - design/icache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/icache_tb.sv

//--- design/icache_addr_pkg.sv
// Core-side address types of the instruction cache
// Tag, index and word offset fields, plus helpers that split a byte address

`include "icache_defines.svh"

`default_nettype none

package icache_addr_pkg;

  // Field widths, low to high: byte in word, word in line, index, tag
  localparam int ADDR_W   = `ICACHE_ADDR_W;
  localparam int BYTE_W   = $clog2(`ICACHE_WORD_W / 8);
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int INDEX_W  = $clog2(`ICACHE_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Upper bits, stored in the tag array
  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  // Selects the set
  function automatic index_t addr_index(addr_t a);
    return a[BYTE_W+OFFSET_W +: INDEX_W];
  endfunction

  // Word within the line
  function automatic offset_t addr_offset(addr_t a);
    return a[BYTE_W +: OFFSET_W];
  endfunction

  // First byte of the line, used as the memory fetch address
  function automatic addr_t line_base(addr_t a);
    return {a[ADDR_W-1:BYTE_W+OFFSET_W], {(BYTE_W + OFFSET_W){1'b0}}};
  endfunction

endpackage

`default_nettype wire

//--- design/icache_compare.sv
// Stage 2 of the instruction cache
// Tag and valid check, registered hit response or one-cycle miss pulse

`include "icache_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module icache_compare (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      s1_valid,
  input  wire icache_addr_pkg::addr_t    s1_addr,
  input  wire icache_addr_pkg::tag_t     tag_dout,
  input  wire icache_line_pkg::word_t    data_dout,
  input  wire logic [`ICACHE_SETS-1:0]   valid_bits,
  output logic                           hit_valid,
  output icache_line_pkg::word_t         hit_data,
  output logic                           miss,
  output icache_addr_pkg::addr_t         miss_addr
);

  // Set and tag of the stage 1 request
  icache_addr_pkg::index_t s1_index;
  icache_addr_pkg::tag_t   s1_tag;

  logic line_valid;
  logic tag_match;
  logic hit;

  assign s1_index = icache_addr_pkg::addr_index(s1_addr);
  assign s1_tag   = icache_addr_pkg::addr_tag(s1_addr);

  // *********************************************************
  // Hit detect
  // *********************************************************

  // Valid bit first, so an unwritten tag never counts
  assign line_valid = valid_bits[s1_index];
  assign tag_match  = (tag_dout == s1_tag);
  assign hit        = s1_valid && line_valid && tag_match;

  // Response strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_valid <= 1'b0;
      miss      <= 1'b0;
    end else begin
      hit_valid <= hit;
      // Any request that does not hit goes to refill
      miss      <= s1_valid && !hit;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (hit) begin
      hit_data <= data_dout;
    end
    if (s1_valid) begin
      miss_addr <= s1_addr;
    end
  end

  // One answer per request
  a_hit_xor_miss: assert property (
    @(posedge clk) disable iff (rst) !(hit_valid && miss)
  );

endmodule

`default_nettype wire

//--- design/icache_line_pkg.sv
// Storage-side types of the instruction cache
// Instruction word and data-array address, which is index and word offset

`include "icache_defines.svh"

`default_nettype none

package icache_line_pkg;

  // One instruction, also one memory beat
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

  // Data array holds every word of every line, index in the upper bits
  localparam int DARR_ADDR_W = icache_addr_pkg::INDEX_W + icache_addr_pkg::OFFSET_W;

  typedef logic [DARR_ADDR_W-1:0] darr_addr_t;

  // Word slot of a line in the data array
  function automatic darr_addr_t darr_addr(
    icache_addr_pkg::index_t  idx,
    icache_addr_pkg::offset_t off
  );
    return {idx, off};
  endfunction

endpackage

`default_nettype wire

//--- design/icache_lookup.sv
// Stage 1 of the instruction cache
// Starts tag and data reads in the request cycle and registers the request

`timescale 1ns/1ns
`default_nettype none

module icache_lookup (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        req,
  input  wire icache_addr_pkg::addr_t      req_addr,
  input  wire logic                        busy,
  output logic                             tag_ce,
  output icache_addr_pkg::index_t          tag_addr,
  output logic                             data_ce,
  output icache_line_pkg::darr_addr_t      data_addr,
  output logic                             s1_valid,
  output icache_addr_pkg::addr_t           s1_addr
);

  // Fields of the incoming address
  icache_addr_pkg::index_t  req_index;
  icache_addr_pkg::offset_t req_offset;

  assign req_index  = icache_addr_pkg::addr_index(req_addr);
  assign req_offset = icache_addr_pkg::addr_offset(req_addr);

  // *********************************************************
  // Array reads
  // *********************************************************

  // Both arrays latch on the request edge, outputs settle in stage 2
  assign tag_ce    = req;
  assign tag_addr  = req_index;
  assign data_ce   = req;
  assign data_addr = icache_line_pkg::darr_addr(req_index, req_offset);

  // *********************************************************
  // Stage register
  // *********************************************************

  // Lines up with tag_dout and data_dout one edge later
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req;
    end
  end

  // Address payload, held between requests
  always_ff @(posedge clk) begin
    if (req) begin
      s1_addr <= req_addr;
    end
  end

  // Core may only issue while the refill engine is idle
  a_no_req_when_busy: assert property (
    @(posedge clk) disable iff (rst) req |-> !busy
  );

endmodule

`default_nettype wire

//--- design/icache_refill.sv
// Miss handler of the instruction cache
// Line fetch FSM, array writes, requested-word capture and the valid vector

`include "icache_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module icache_refill (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      miss,
  input  wire icache_addr_pkg::addr_t    miss_addr,
  input  wire logic                      flush,
  input  wire logic                      mem_valid,
  input  wire icache_line_pkg::word_t    mem_data,
  output logic                           mem_req,
  output icache_addr_pkg::addr_t         mem_addr,
  output logic                           busy,
  output logic                           wr_ce,
  output logic                           wr_we,
  output icache_addr_pkg::index_t        wr_tag_addr,
  output icache_addr_pkg::tag_t          wr_tag,
  output icache_line_pkg::darr_addr_t    wr_data_addr,
  output icache_line_pkg::word_t         wr_data,
  output logic [`ICACHE_SETS-1:0]        valid_bits,
  output logic                           fill_valid,
  output icache_line_pkg::word_t         fill_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_FILL
  } state_t;

  state_t state;

  // Line being fetched and the word the core asked for
  icache_addr_pkg::addr_t   line_q;
  icache_addr_pkg::offset_t want_q;
  // Offset of the next beat
  icache_addr_pkg::offset_t beat_q;

  logic beat;
  logic last_beat;

  // Beats only count once the request has gone out
  assign beat      = (state == ST_FILL) && mem_valid;
  assign last_beat = beat && (beat_q == '1);

  // *********************************************************
  // Outputs
  // *********************************************************

  assign busy     = (state != ST_IDLE);
  assign mem_req  = (state == ST_REQ);
  assign mem_addr = line_q;

  // Each beat writes its word and the line tag
  // The line stays invalid until the last beat sets its bit
  assign wr_ce        = beat;
  assign wr_we        = beat;
  assign wr_tag_addr  = icache_addr_pkg::addr_index(line_q);
  assign wr_tag       = icache_addr_pkg::addr_tag(line_q);
  assign wr_data_addr = icache_line_pkg::darr_addr(wr_tag_addr, beat_q);
  assign wr_data      = mem_data;

  // *********************************************************
  // FSM
  // *********************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      beat_q     <= '0;
      valid_bits <= '0;
      fill_valid <= 1'b0;
    end else begin
      // Response goes out with busy falling
      fill_valid <= last_beat;
      case (state)
        ST_IDLE: begin
          // Flush only acts between refills
          if (flush) begin
            valid_bits <= '0;
          end
          if (miss) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          // mem_req is high for this one cycle
          beat_q <= '0;
          state  <= ST_FILL;
        end
        ST_FILL: begin
          if (beat) begin
            beat_q <= beat_q + 1'b1;
          end
          if (last_beat) begin
            valid_bits[wr_tag_addr] <= 1'b1;
            state                   <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // *********************************************************
  // Miss capture
  // *********************************************************

  always_ff @(posedge clk) begin
    if (miss && (state == ST_IDLE)) begin
      line_q <= icache_addr_pkg::line_base(miss_addr);
      want_q <= icache_addr_pkg::addr_offset(miss_addr);
    end
    // Keep the requested word as it streams past
    if (beat && (beat_q == want_q)) begin
      fill_data <= mem_data;
    end
  end

  // Memory only answers a request already sent
  a_beat_in_fill: assert property (
    @(posedge clk) disable iff (rst) mem_valid |-> (state == ST_FILL)
  );

endmodule

`default_nettype wire

//--- design/icache_top.sv
// Top of the read-only instruction cache
// Lookup, compare and refill stages, tag and data arrays, array port mux

`include "icache_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module icache_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      req,
  input  wire icache_addr_pkg::addr_t    req_addr,
  input  wire logic                      flush,
  output logic                           busy,
  output logic                           resp_valid,
  output icache_line_pkg::word_t         resp_data,
  output logic                           mem_req,
  output icache_addr_pkg::addr_t         mem_addr,
  input  wire logic                      mem_valid,
  input  wire icache_line_pkg::word_t    mem_data
);

  // Lookup side of the arrays
  logic                        lk_tag_ce;
  logic                        lk_data_ce;
  icache_addr_pkg::index_t     lk_tag_addr;
  icache_line_pkg::darr_addr_t lk_data_addr;

  // Stage 1 to stage 2
  logic                        s1_valid;
  icache_addr_pkg::addr_t      s1_addr;
  icache_addr_pkg::tag_t       tag_dout;
  icache_line_pkg::word_t      data_dout;

  // Stage 2 results
  logic                        hit_valid;
  icache_line_pkg::word_t      hit_data;
  logic                        miss;
  icache_addr_pkg::addr_t      miss_addr;

  // Refill side of the arrays
  logic                        wr_ce;
  logic                        wr_we;
  icache_addr_pkg::index_t     wr_tag_addr;
  icache_addr_pkg::tag_t       wr_tag;
  icache_line_pkg::darr_addr_t wr_data_addr;
  icache_line_pkg::word_t      wr_data;
  logic [`ICACHE_SETS-1:0]     valid_bits;
  logic                        fill_valid;
  icache_line_pkg::word_t      fill_data;

  // Muxed array ports
  logic                        tag_ce;
  logic                        tag_we;
  icache_addr_pkg::index_t     tag_addr;
  logic                        data_ce;
  logic                        data_we;
  icache_line_pkg::darr_addr_t data_addr;

  icache_lookup u_lookup (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_addr  (req_addr),
    .busy      (busy),
    .tag_ce    (lk_tag_ce),
    .tag_addr  (lk_tag_addr),
    .data_ce   (lk_data_ce),
    .data_addr (lk_data_addr),
    .s1_valid  (s1_valid),
    .s1_addr   (s1_addr)
  );

  icache_compare u_compare (
    .clk        (clk),
    .rst        (rst),
    .s1_valid   (s1_valid),
    .s1_addr    (s1_addr),
    .tag_dout   (tag_dout),
    .data_dout  (data_dout),
    .valid_bits (valid_bits),
    .hit_valid  (hit_valid),
    .hit_data   (hit_data),
    .miss       (miss),
    .miss_addr  (miss_addr)
  );

  icache_refill u_refill (
    .clk          (clk),
    .rst          (rst),
    .miss         (miss),
    .miss_addr    (miss_addr),
    .flush        (flush),
    .mem_valid    (mem_valid),
    .mem_data     (mem_data),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .busy         (busy),
    .wr_ce        (wr_ce),
    .wr_we        (wr_we),
    .wr_tag_addr  (wr_tag_addr),
    .wr_tag       (wr_tag),
    .wr_data_addr (wr_data_addr),
    .wr_data      (wr_data),
    .valid_bits   (valid_bits),
    .fill_valid   (fill_valid),
    .fill_data    (fill_data)
  );

  // *********************************************************
  // Array port mux
  // *********************************************************

  // Refill owns both arrays while busy, lookup never writes
  assign tag_ce    = busy ? wr_ce : lk_tag_ce;
  assign tag_we    = busy && wr_we;
  assign tag_addr  = busy ? wr_tag_addr : lk_tag_addr;
  assign data_ce   = busy ? wr_ce : lk_data_ce;
  assign data_we   = busy && wr_we;
  assign data_addr = busy ? wr_data_addr : lk_data_addr;

  sram_1p #(
    .DEPTH     (`ICACHE_SETS),
    .payload_t (icache_addr_pkg::tag_t)
  ) u_tag (
    .clk  (clk),
    .ce   (tag_ce),
    .we   (tag_we),
    .addr (tag_addr),
    .din  (wr_tag),
    .dout (tag_dout)
  );

  sram_1p #(
    .DEPTH     (`ICACHE_SETS * `ICACHE_LINE_WORDS),
    .payload_t (icache_line_pkg::word_t)
  ) u_data (
    .clk  (clk),
    .ce   (data_ce),
    .we   (data_we),
    .addr (data_addr),
    .din  (wr_data),
    .dout (data_dout)
  );

  // *********************************************************
  // Response
  // *********************************************************

  // Hit and fill strobes never overlap, data follows the active strobe
  assign resp_valid = hit_valid || fill_valid;
  assign resp_data  = fill_valid ? fill_data : hit_data;

endmodule

`default_nettype wire

//--- design/sram_1p.sv
// Behavioral single-port RAM
// Chip and write enable, address registered on the edge, combinational read
// Payload type given as a type parameter

`timescale 1ns/1ns
`default_nettype none

module sram_1p #(
  parameter int  DEPTH     = 64,
  parameter type payload_t = logic [31:0]
) (
  input  wire logic                     clk,
  input  wire logic                     ce,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] addr,
  input  wire payload_t                 din,
  output payload_t                      dout
);

  // Storage, no reset
  payload_t mem [DEPTH];

  // Address of the last enabled access
  logic [$clog2(DEPTH)-1:0] addr_q;

  // *********************************************************
  // Access
  // *********************************************************

  // Address only moves while the chip is enabled
  always_ff @(posedge clk) begin
    if (ce) begin
      addr_q <= addr;
    end
  end

  always_ff @(posedge clk) begin
    if (ce && we) begin
      mem[addr] <= din;
    end
  end

  // Read after the edge, from the latched address
  // A write shows its new data through the same address
  assign dout = mem[addr_q];

  // Callers hold we low whenever the chip is idle
  a_we_with_ce: assert property (@(posedge clk) we |-> ce);

endmodule

`default_nettype wire

//--- icache.f
+incdir+include
design/icache_addr_pkg.sv
design/icache_line_pkg.sv
design/sram_1p.sv
design/icache_lookup.sv
design/icache_compare.sv
design/icache_refill.sv
design/icache_top.sv
tests/icache_tb.sv

//--- include/icache_defines.svh
// Build-time sizes of the instruction cache
// Address width, set count, line length, beat width and memory delay bound

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

`default_nettype none

// *********************************************************
// Geometry
// *********************************************************

// Byte address width on the core and the memory side
`define ICACHE_ADDR_W 32

// Direct-mapped, so one line per set
`define ICACHE_SETS 64

// Instruction words per line, a power of two
`define ICACHE_LINE_WORDS 4

// *********************************************************
// Memory port
// *********************************************************

// One instruction word per memory beat
`define ICACHE_WORD_W 32

// Longest delay in cycles from mem_req to the first beat
`define ICACHE_MEM_LAT_MAX 8

`default_nettype wire

`endif

//--- tests/icache_tb.sv
// Testbench for the read-only instruction cache
// Clock, reset, memory responder, reference model of tags and valid flags
// Directed tests for cold miss, hit, word select, conflict and flush, then a random mix

`include "icache_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module icache_tb;

  // Address fields, worked out here from the sizes alone
  localparam int OFF_LSB    = 2;
  localparam int IDX_LSB    = OFF_LSB + $clog2(`ICACHE_LINE_WORDS);
  localparam int TAG_LSB    = IDX_LSB + $clog2(`ICACHE_SETS);
  localparam int LINE_BYTES = `ICACHE_LINE_WORDS * 4;

  // Memory content rule
  localparam logic [31:0] MEM_KEY = 32'hC0DE_0000;

  // Request counts of each test
  localparam int N_COLD     = 8;
  localparam int N_WORD_SEL = 16;
  localparam int N_CONFLICT = 8;
  localparam int N_RANDOM   = 400;
  // Cold, hit, word select, conflict, flush, random
  localparam int TOTAL_REQ  = N_COLD + N_COLD + N_WORD_SEL + N_CONFLICT + N_COLD + N_RANDOM;
  // Worst refill per request plus pipeline and idle slack
  localparam int TIMEOUT_CYCLES =
    TOTAL_REQ * (`ICACHE_LINE_WORDS * `ICACHE_MEM_LAT_MAX + 10);

  logic                   clk;
  logic                   rst;
  logic                   req;
  icache_addr_pkg::addr_t req_addr;
  logic                   flush;
  logic                   busy;
  logic                   resp_valid;
  icache_line_pkg::word_t resp_data;
  logic                   mem_req;
  icache_addr_pkg::addr_t mem_addr;
  logic                   mem_valid;
  icache_line_pkg::word_t mem_data;

  integer seed;
  integer resp_seed;
  int     errors;
  int     checks;
  int     req_count;
  int     resp_count  = 0;
  int     cycle_count = 0;

  // Set by the responder when a line fetch starts
  logic                   mem_req_seen;
  icache_addr_pkg::addr_t mem_req_addr;

  // Reference model, one tag and valid flag per set
  logic        model_valid [`ICACHE_SETS];
  int unsigned model_tag   [`ICACHE_SETS];

  icache_addr_pkg::addr_t cold_line [N_COLD];

  icache_top DUT (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_addr   (req_addr),
    .flush      (flush),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data)
  );

  always #2 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Every response strobe, counted at the stable point of the cycle
  always @(negedge clk) begin
    if (!rst && resp_valid) begin
      resp_count++;
    end
  end

  // *********************************************************
  // Memory responder
  // *********************************************************

  initial begin
    int                     delay;
    int                     beat;
    icache_addr_pkg::addr_t base;
    mem_valid = 1'b0;
    mem_data  = '0;
    resp_seed = 32'h3a977705;
    forever begin
      @(negedge clk);
      if (mem_req) begin
        mem_req_seen = 1'b1;
        mem_req_addr = mem_addr;
        base         = mem_addr;
        delay        = 1 + ($unsigned($random(resp_seed)) % `ICACHE_MEM_LAT_MAX);
        repeat (delay) @(negedge clk);
        // Beats in word order, sometimes with a gap
        for (beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
          mem_valid = 1'b1;
          mem_data  = (base + beat * 4) ^ MEM_KEY;
          @(negedge clk);
          if ((beat < `ICACHE_LINE_WORDS - 1) && (($random(resp_seed) & 1) != 0)) begin
            mem_valid = 1'b0;
            @(negedge clk);
          end
        end
        mem_valid = 1'b0;
      end
    end
  end

  // *********************************************************
  // Helpers and checks
  // *********************************************************

  function automatic int rand_range(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic icache_addr_pkg::addr_t make_addr(int unsigned tag, int unsigned idx,
                                                        int unsigned off);
    return (tag << TAG_LSB) | (idx << IDX_LSB) | (off << OFF_LSB);
  endfunction

  task automatic check_word(input string name, input icache_line_pkg::word_t exp,
                            input icache_line_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Hit is taken as no line fetch during the request
  task automatic check_hit(input string name, input logic exp_hit, input logic fetched);
    checks++;
    if (fetched !== !exp_hit) begin
      errors++;
      $display("ERROR %s hit: expected %b, actual %b", name, exp_hit, !fetched);
    end
  endtask

  task automatic check_addr(input string name, input icache_addr_pkg::addr_t exp,
                            input icache_addr_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s mem_addr: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // One request, waits for its response and checks it against the model
  task automatic issue_request(input string name, input icache_addr_pkg::addr_t addr);
    icache_addr_pkg::addr_t a;
    icache_addr_pkg::addr_t line;
    int                     idx;
    int unsigned            tag;
    logic                   exp_hit;
    icache_line_pkg::word_t exp_word;
    int                     cycles;
    a        = addr & ~32'h3;
    line     = a & ~(LINE_BYTES - 1);
    idx      = (a >> IDX_LSB) % `ICACHE_SETS;
    tag      = a >> TAG_LSB;
    exp_hit  = model_valid[idx] && (model_tag[idx] == tag);
    exp_word = a ^ MEM_KEY;
    @(negedge clk);
    mem_req_seen = 1'b0;
    req          = 1'b1;
    req_addr     = a;
    @(negedge clk);
    req    = 1'b0;
    cycles = 1;
    while (!resp_valid) begin
      @(negedge clk);
      cycles++;
    end
    check_word(name, exp_word, resp_data);
    check_hit(name, exp_hit, mem_req_seen);
    // Busy drops with the response, so the core may issue again
    check_flag({name, " busy"}, 1'b0, busy);
    // A hit answers two cycles after the request
    if (exp_hit) begin
      check_count({name, " latency"}, 2, cycles);
    end else begin
      check_addr(name, line, mem_req_addr);
    end
    model_valid[idx] = 1'b1;
    model_tag[idx]   = tag;
    req_count++;
  endtask

  // One-cycle flush while the cache is idle
  task automatic flush_cache();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  // *********************************************************
  // Test sequence
  // *********************************************************

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    req          = 1'b0;
    req_addr     = '0;
    flush        = 1'b0;
    mem_req_seen = 1'b0;
    mem_req_addr = '0;
    seed         = 32'h3a977705;
    errors       = 0;
    checks       = 0;
    req_count    = 0;
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = 0;
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset resp_valid", 1'b0, resp_valid);
    check_flag("reset mem_req", 1'b0, mem_req);

    // Cold misses on spread-out sets
    for (int i = 0; i < N_COLD; i++) begin
      cold_line[i] = make_addr(1, i * 8, 0);
      issue_request("cold_miss", cold_line[i] + 4 * rand_range(`ICACHE_LINE_WORDS));
    end

    // Same lines again
    for (int i = 0; i < N_COLD; i++) begin
      issue_request("hit", cold_line[i] + 4 * rand_range(`ICACHE_LINE_WORDS));
    end

    // Any word of a resident line
    for (int i = 0; i < N_WORD_SEL; i++) begin
      issue_request("word_select",
                    cold_line[rand_range(N_COLD)] + 4 * rand_range(`ICACHE_LINE_WORDS));
    end

    // Two tags fighting over set 3
    for (int i = 0; i < N_CONFLICT; i++) begin
      issue_request("conflict", make_addr(5 + (i % 2), 3, rand_range(`ICACHE_LINE_WORDS)));
    end

    // Lines resident before the flush miss again
    flush_cache();
    for (int i = 0; i < N_COLD; i++) begin
      issue_request("flush", cold_line[i] + 4 * rand_range(`ICACHE_LINE_WORDS));
    end

    // Small tag and set range for plenty of hits and evictions
    for (int i = 0; i < N_RANDOM; i++) begin
      repeat (rand_range(3)) @(negedge clk);
      if (rand_range(40) == 0) begin
        flush_cache();
      end
      issue_request("random",
                    make_addr(rand_range(4), rand_range(16), rand_range(`ICACHE_LINE_WORDS)));
    end

    // Let any stray response show up
    repeat (4) @(negedge clk);
    check_count("resp_count", req_count, resp_count);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
